// ==== video_pkg.sv ====
/*
 * video timing struct and screen geometry constants
 */
`default_nettype none

package video_pkg;

    // pixels per line and width of the horizontal count
    localparam int LINE_W = 512;
    localparam int HPOS_W = 9;

    // timing from the video generator, sampled on clk
    typedef struct packed {
        logic [7:0]        v;      // line number
        logic [HPOS_W-1:0] h;      // horizontal count
        logic              lhbl;   // high during active display
        logic              hinit;  // line start strobe
        logic              flip;   // screen flip
    } vid_t;

endpackage

`default_nettype wire

// ==== obj_pkg.sv ====
/*
 * object attribute, pixel and line buffer write structs
 * draw FSM states and object table constants
 */
`default_nettype none

package obj_pkg;

    import video_pkg::*;

    localparam int              OBJ_IDX_W = 5;
    localparam int              OBJ_NUM   = 32;
    localparam int              OBJ_SIZE  = 16;
    localparam int              ROM_AW    = 17;
    // last value of the buffer wait count
    localparam logic [3:0]      BUF_WAIT  = 4'd10;
    // scan stops after this object
    localparam logic [OBJ_IDX_W-1:0] OBJ_LAST = 5'd23;

    // one entry of the object table
    typedef struct packed {
        logic [8:0] code;
        logic [3:0] color;
        logic       hflip;
        logic       vflip;
        logic [7:0] y;
        logic [8:0] x;
    } obj_attr_t;

    // pal of zero is transparent
    typedef struct packed {
        logic [3:0] color;
        logic [3:0] pal;
    } obj_pxl_t;

    typedef struct packed {
        logic              we;
        logic [HPOS_W-1:0] addr;
        obj_pxl_t          pxl;
    } lbuf_wr_t;

    typedef enum logic [2:0] {
        ST_WAIT,
        ST_READ,
        ST_TEST,
        ST_DRAW,
        ST_SKIP
    } draw_state_e;

endpackage

`default_nettype wire

// ==== obj_timing.sv ====
/*
 * per line counters for buffer wait, pixel step and object index
 * scan over flag and line bank toggle
 */
`timescale 1ns/1ps
`default_nettype none

module obj_timing
    import video_pkg::*, obj_pkg::*;
#(
    parameter int LAYOUT = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic                 cen6,
    input  wire vid_t                 vid,
    input  wire logic                 rom_ok,
    output logic [3:0]                pxlcnt,
    output logic                      pxlcnt_lsb,
    output logic [3:0]                bufcnt,
    output logic [OBJ_IDX_W-1:0]      objcnt,
    output logic                      over,
    output logic                      line
);

    logic                 last_lhbl;
    logic                 ok_dly;
    logic                 rom_good;
    logic                 lhbl_rise;
    logic [OBJ_IDX_W-1:0] auxcnt;

    // rom answer only counts after two high cycles in a row
    assign rom_good  = rom_ok & ok_dly;
    assign lhbl_rise = vid.lhbl & ~last_lhbl;

    // layout 0 swaps the upper halves of the table
    // on one side of the screen, this makes the logo effect
    always_comb begin
        objcnt = auxcnt;
        if (LAYOUT == 0 && (vid.v[7] ^ vid.flip) && auxcnt > 5'd15) begin
            objcnt[3] = ~auxcnt[3];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_lhbl  <= 1'b0;
            ok_dly     <= 1'b0;
            pxlcnt     <= 4'd0;
            pxlcnt_lsb <= 1'b0;
            // idle until the first active line
            bufcnt     <= BUF_WAIT;
            auxcnt     <= '0;
            over       <= 1'b1;
        end else begin
            last_lhbl <= vid.lhbl;
            ok_dly    <= rom_ok;
            if (lhbl_rise) begin
                // new scan
                pxlcnt     <= 4'd0;
                pxlcnt_lsb <= 1'b0;
                bufcnt     <= 4'd0;
                auxcnt     <= '0;
                over       <= 1'b0;
            end else if (bufcnt != BUF_WAIT) begin
                bufcnt <= bufcnt + 4'd1;
            end else if (rom_good && !over) begin
                {pxlcnt, pxlcnt_lsb} <= {pxlcnt, pxlcnt_lsb} + 5'd1;
                // 32 steps done, move to the next object
                if (&{pxlcnt, pxlcnt_lsb}) begin
                    bufcnt <= 4'd0;
                    auxcnt <= auxcnt + 5'd1;
                    over   <= auxcnt == OBJ_LAST;
                end
            end else if (!rom_good) begin
                // present the address again
                pxlcnt_lsb <= 1'b0;
            end
        end
    end

    // line bank flips once per line
    always_ff @(posedge clk) begin
        if (rst) begin
            line <= 1'b0;
        end else if (cen6 && vid.hinit) begin
            line <= ~line;
        end
    end

    // the wait count saturates and only restarts from zero
    a_bufcnt_range: assert property (@(posedge clk) disable iff (rst)
        bufcnt <= BUF_WAIT);

endmodule

`default_nettype wire

// ==== obj_attr_ram.sv ====
/*
 * object attribute table, cpu write port and registered scan read
 */
`timescale 1ns/1ps
`default_nettype none

module obj_attr_ram
    import obj_pkg::*;
(
    input  wire logic                 clk,
    input  wire logic                 cpu_we,
    input  wire logic [OBJ_IDX_W-1:0] cpu_addr,
    input  wire obj_attr_t            cpu_data,
    input  wire logic [OBJ_IDX_W-1:0] rd_addr,
    output obj_attr_t                 rd_attr
);

    // simple dual port table, one entry per object
    obj_attr_t mem [OBJ_NUM];

    // cpu side, one write per cycle
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= cpu_data;
        end
    end

    // scan side, data one cycle after the index
    always_ff @(posedge clk) begin
        rd_attr <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== obj_draw.sv ====
/*
 * object draw FSM: attribute latch, vertical hit test,
 * rom address and line buffer writes
 */
`timescale 1ns/1ps
`default_nettype none

module obj_draw
    import video_pkg::*, obj_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire obj_attr_t         attr,
    input  wire vid_t              vid,
    input  wire logic [3:0]        bufcnt,
    input  wire logic [3:0]        pxlcnt,
    input  wire logic              pxlcnt_lsb,
    input  wire logic              rom_ok,
    input  wire logic [3:0]        rom_data,
    output logic [ROM_AW-1:0]      rom_addr,
    output lbuf_wr_t               wr
);

    draw_state_e       state;
    logic              ok_dly;
    logic              step_ok;
    logic [7:0]        dv;
    logic [3:0]        col;

    // latched object
    logic [8:0]        code;
    logic [3:0]        color;
    logic              hflip;
    logic [HPOS_W-1:0] xpos;
    logic [3:0]        row;

    // line offset inside the object, mod 256
    assign dv = vid.v - attr.y;

    // data half of an accepted pixel step
    assign step_ok = rom_ok & ok_dly & pxlcnt_lsb & (bufcnt == BUF_WAIT);

    assign rom_addr = {code, row, pxlcnt};

    // column on screen, mirrored by hflip
    assign col = pxlcnt ^ {4{hflip}};

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= ST_WAIT;
            ok_dly <= 1'b0;
        end else begin
            ok_dly <= rom_ok;
            case (state)
                ST_WAIT: begin
                    if (bufcnt == 4'd0) begin
                        state <= ST_READ;
                    end
                end
                // table read in flight
                ST_READ: state <= ST_TEST;
                ST_TEST: begin
                    if (dv < OBJ_SIZE) begin
                        state <= ST_DRAW;
                    end else begin
                        state <= ST_SKIP;
                    end
                end
                // hold until the next object slot
                ST_DRAW, ST_SKIP: begin
                    if (bufcnt == 4'd0) begin
                        state <= ST_READ;
                    end
                end
                default: state <= ST_WAIT;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_TEST) begin
            code  <= attr.code;
            color <= attr.color;
            hflip <= attr.hflip;
            xpos  <= attr.x;
            // row counted from the bottom when vflip is set
            row   <= dv[3:0] ^ {4{attr.vflip}};
        end
    end

    // one write per opaque pixel with the address wrapping at 9 bits
    always_ff @(posedge clk) begin
        wr.addr <= xpos + {5'd0, col};
        wr.pxl  <= '{color: color, pal: rom_data};
        if (rst) begin
            wr.we <= 1'b0;
        end else begin
            wr.we <= (state == ST_DRAW) && step_ok && (rom_data != 4'd0);
        end
    end

    // a write lands while its own slot is still drawing
    a_we_in_draw: assert property (@(posedge clk) disable iff (rst)
        wr.we |-> state == ST_DRAW);

endmodule

`default_nettype wire

// ==== obj_line_buffer.sv ====
/*
 * double line buffer, two banks of one line each
 * draw side writes, display side reads and clears
 */
`timescale 1ns/1ps
`default_nettype none

module obj_line_buffer
    import video_pkg::*, obj_pkg::*;
(
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              line,
    input  wire lbuf_wr_t          wr,
    input  wire logic [HPOS_W-1:0] rd_addr,
    input  wire logic              rd_en,
    output obj_pxl_t               pxl
);

    obj_pxl_t bank_q [2];
    logic     rd_vld;
    logic     rd_sel;

    for (genvar b = 0; b < 2; b++) begin : g_bank
        // contents start out transparent
        obj_pxl_t mem [LINE_W] = '{default: '0};

        always_ff @(posedge clk) begin
            if (line == 1'(b)) begin
                // bank being drawn
                if (wr.we) begin
                    mem[wr.addr] <= wr.pxl;
                end
            end else if (rd_en) begin
                // bank on display, clear behind the read
                bank_q[b]    <= mem[rd_addr];
                mem[rd_addr] <= '0;
            end
        end
    end

    // remember which bank the last read came from
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_vld <= 1'b0;
            rd_sel <= 1'b0;
        end else begin
            rd_vld <= rd_en;
            rd_sel <= ~line;
        end
    end

    // background is zero outside the active part
    assign pxl = rd_vld ? bank_q[rd_sel] : '0;

    // draw writes never land on the bank whose read is in flight
    a_bank_split: assert property (@(posedge clk) disable iff (rst)
        wr.we && rd_vld |-> line != rd_sel);

endmodule

`default_nettype wire

// ==== obj_top.sv ====
/*
 * object line engine top: timing, table, draw FSM and line buffer
 */
`timescale 1ns/1ps
`default_nettype none

module obj_top
    import video_pkg::*, obj_pkg::*;
#(
    parameter int LAYOUT = 0
) (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire vid_t                 vid,
    input  wire logic                 cen6,
    input  wire logic                 cpu_we,
    input  wire logic [OBJ_IDX_W-1:0] cpu_addr,
    input  wire obj_attr_t            cpu_data,
    output logic [ROM_AW-1:0]         rom_addr,
    input  wire logic [3:0]           rom_data,
    input  wire logic                 rom_ok,
    output obj_pxl_t                  obj_pxl,
    output logic                      scan_done
);

    logic [OBJ_IDX_W-1:0] objcnt;
    logic [3:0]           pxlcnt;
    logic                 pxlcnt_lsb;
    logic [3:0]           bufcnt;
    logic                 line;
    obj_attr_t            attr;
    lbuf_wr_t             wr;

    obj_timing #(
        .LAYOUT (LAYOUT)
    ) u_timing (
        .clk        (clk),
        .rst        (rst),
        .cen6       (cen6),
        .vid        (vid),
        .rom_ok     (rom_ok),
        .pxlcnt     (pxlcnt),
        .pxlcnt_lsb (pxlcnt_lsb),
        .bufcnt     (bufcnt),
        .objcnt     (objcnt),
        .over       (scan_done),
        .line       (line)
    );

    obj_attr_ram u_attr_ram (
        .clk      (clk),
        .cpu_we   (cpu_we),
        .cpu_addr (cpu_addr),
        .cpu_data (cpu_data),
        .rd_addr  (objcnt),
        .rd_attr  (attr)
    );

    obj_draw u_draw (
        .clk        (clk),
        .rst        (rst),
        .attr       (attr),
        .vid        (vid),
        .bufcnt     (bufcnt),
        .pxlcnt     (pxlcnt),
        .pxlcnt_lsb (pxlcnt_lsb),
        .rom_ok     (rom_ok),
        .rom_data   (rom_data),
        .rom_addr   (rom_addr),
        .wr         (wr)
    );

    // display side reads at the horizontal count during active video
    obj_line_buffer u_line_buffer (
        .clk     (clk),
        .rst     (rst),
        .line    (line),
        .wr      (wr),
        .rd_addr (vid.h),
        .rd_en   (vid.lhbl),
        .pxl     (obj_pxl)
    );

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
/*
 * testbench clock and synchronous reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter real PERIOD     = 8.0,
    parameter int  RST_CYCLES = 2
) (
    output logic clk = 1'b0,
    output logic rst
);

    initial begin
        forever #(PERIOD / 2.0) clk = ~clk;
    end

    // reset held for a few rising edges and released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

`default_nettype wire

// ==== obj_tb.sv ====
/*
 * object line engine testbench: video timing, ROM model,
 * scene table, reference line model, checks and timeout
 */
`timescale 1ns/1ps
`default_nettype none

module obj_tb
    import video_pkg::*, obj_pkg::*;
;
    localparam int LAYOUT  = 0;
    localparam int NROW    = 8;
    localparam int TIMEOUT = NROW * 2 * 2048 * 11 / 10;

    logic clk, rst, cen6, cpu_we, rom_ok, scan_done;
    logic [OBJ_IDX_W-1:0] cpu_addr;
    logic [ROM_AW-1:0] rom_addr;
    logic [3:0] rom_data;
    vid_t vid;
    obj_attr_t cpu_data;
    obj_pxl_t obj_pxl;

    // scene table
    obj_attr_t scene_obj [NROW][OBJ_NUM];
    logic [7:0] scene_v [NROW];
    logic scene_flip [NROW];
    int scene_cnt [NROW];
    logic scene_done [NROW];

    obj_pxl_t exp_line [LINE_W];
    obj_pxl_t cap_line [LINE_W];
    logic [7:0] next_v;
    logic next_flip, cap_pend, cap_done, drop;
    logic [HPOS_W-1:0] cap_h;
    logic [1:0] phase;
    int line_cnt, cycles, pxl_err, bit_err, cnt_err;

    tb_clk_gen #(.PERIOD(8.0), .RST_CYCLES(2)) u_clk (.clk(clk), .rst(rst));

    obj_top #(.LAYOUT(LAYOUT)) dut (
        .clk(clk), .rst(rst), .vid(vid), .cen6(cen6),
        .cpu_we(cpu_we), .cpu_addr(cpu_addr), .cpu_data(cpu_data),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok),
        .obj_pxl(obj_pxl), .scan_done(scan_done)
    );

    // graphics ROM contents
    function automatic logic [3:0] rom_pixel(logic [ROM_AW-1:0] a);
        return 4'(a ^ (a >> 5));
    endfunction

    function automatic obj_attr_t make_obj(int code, int color, bit hf, bit vf, int y, int x);
        obj_attr_t a;
        a.code  = 9'(code);
        a.color = 4'(color);
        a.hflip = hf;
        a.vflip = vf;
        a.y     = 8'(y);
        a.x     = 9'(x);
        return a;
    endfunction

    // empty entries sit far below the line so they never hit
    task automatic set_scene(int r, int v, bit flip, int cnt);
        scene_v[r]    = 8'(v);
        scene_flip[r] = flip;
        scene_cnt[r]  = cnt;
        scene_done[r] = 1'b1;
        for (int i = 0; i < OBJ_NUM; i++) scene_obj[r][i] = make_obj(0, 0, 0, 0, v + 64, 0);
    endtask

    task automatic build_table();
        set_scene(0, 40, 0, 15);
        scene_obj[0][0] = make_obj(3, 5, 0, 0, 40, 100);
        set_scene(1, 50, 0, 30);
        scene_obj[1][0] = make_obj(6, 1, 1, 0, 45, 60);
        scene_obj[1][1] = make_obj(7, 3, 0, 1, 40, 150);
        // two misses just above and just below the object window
        set_scene(2, 60, 0, 15);
        scene_obj[2][0] = make_obj(8, 4, 0, 0, 44, 80);
        scene_obj[2][1] = make_obj(9, 4, 0, 0, 61, 120);
        scene_obj[2][2] = make_obj(10, 6, 0, 0, 50, 200);
        set_scene(3, 70, 0, 24);
        scene_obj[3][2] = make_obj(1, 2, 0, 0, 70, 100);
        scene_obj[3][5] = make_obj(2, 9, 0, 0, 65, 108);
        // v[7] set swaps the upper half of the table
        set_scene(4, 130, 0, 30);
        scene_obj[4][16] = make_obj(11, 7, 0, 0, 130, 40);
        scene_obj[4][24] = make_obj(12, 8, 0, 0, 130, 48);
        scene_obj[4][20] = make_obj(13, 10, 0, 0, 130, 150);
        scene_obj[4][28] = make_obj(14, 12, 1, 1, 122, 200);
        set_scene(5, 20, 0, 15);
        scene_obj[5][24] = make_obj(15, 13, 0, 0, 20, 30);
        scene_obj[5][10] = make_obj(16, 14, 0, 0, 20, 120);
        // flip alone also swaps
        set_scene(6, 10, 1, 15);
        scene_obj[6][17] = make_obj(17, 15, 0, 0, 10, 220);
        scene_obj[6][31] = make_obj(18, 11, 0, 0, 10, 240);
        set_scene(7, 90, 0, 0);
    endtask

    // line image from the scan rules where later objects overwrite
    task automatic build_expected(int r);
        logic [4:0] idx;
        logic [7:0] dv;
        logic [3:0] row, d, col;
        obj_attr_t a;
        for (int h = 0; h < LINE_W; h++) exp_line[h] = '0;
        for (int raw = 0; raw <= 23; raw++) begin
            idx = 5'(raw);
            if (LAYOUT == 0 && (scene_v[r][7] ^ scene_flip[r]) && raw > 15) idx[3] = ~idx[3];
            a  = scene_obj[r][idx];
            dv = scene_v[r] - a.y;
            if (dv < 8'd16) begin
                row = dv[3:0] ^ {4{a.vflip}};
                for (int p = 0; p < 16; p++) begin
                    d   = rom_pixel({a.code, row, 4'(p)});
                    col = a.hflip ? 4'(15 - p) : 4'(p);
                    if (d != 0) exp_line[9'(a.x + col)] = '{color: a.color, pal: d};
                end
            end
        end
    endtask

    task automatic check_pxl(string name, obj_pxl_t exp, obj_pxl_t act);
        if (exp !== act) begin
            pxl_err++;
            $display("FAILED t=%0t %s expected=%h actual=%h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (exp !== act) begin
            bit_err++;
            $display("FAILED t=%0t %s expected=%b actual=%b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(string name, int exp, int act);
        if (exp != act) begin
            cnt_err++;
            $display("FAILED t=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
        end
    endtask

    // video timing, ROM answers and read-out capture
    always @(negedge clk) begin
        if (cap_pend) begin
            cap_line[cap_h] = obj_pxl;
            cap_pend = 1'b0;
            if (cap_h == 9'd271) cap_done = 1'b1;
        end
        phase = phase + 2'd1;
        cen6  = (phase == 2'd0);
        if (cen6) begin
            vid.h = vid.h + 9'd1;
            if (vid.h == 0) begin
                line_cnt++;
                vid.v    = next_v;
                vid.flip = next_flip;
            end
            vid.hinit = (vid.h == 0);
            vid.lhbl  = (vid.h >= 16 && vid.h <= 271);
            // sample one clock after the first read of each h
            cap_pend = vid.lhbl;
            cap_h    = vid.h;
        end
        // about one clock in four loses the ROM answer
        drop     = ($urandom % 4) == 0;
        rom_ok   = !drop;
        rom_data = rom_pixel(rom_addr);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles, scene loop did not finish", cycles);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    initial begin
        int n;
        void'($urandom(57));
        vid = '0;
        vid.hinit = 1'b1;
        {cen6, cpu_we, cpu_addr, cpu_data, rom_data, rom_ok} = '0;
        {cap_pend, cap_done, drop, cap_h} = '0;
        {line_cnt, cycles, pxl_err, bit_err, cnt_err} = '0;
        phase = 2'd1;
        build_table();
        next_v    = scene_v[0];
        next_flip = scene_flip[0];
        for (int r = 0; r < NROW; r++) begin
            wait (line_cnt == 2 * r + 1);
            // table load during blanking before the scan starts at h 16
            for (int i = 0; i < OBJ_NUM; i++) begin
                @(negedge clk);
                cpu_we   = 1'b1;
                cpu_addr = 5'(i);
                cpu_data = scene_obj[r][i];
            end
            @(negedge clk);
            cpu_we = 1'b0;
            wait (line_cnt == 2 * r + 2);
            check_bit("scan_done", scene_done[r], scan_done);
            cap_done = 1'b0;
            wait (cap_done);
            if (r + 1 < NROW) begin
                next_v    = scene_v[r + 1];
                next_flip = scene_flip[r + 1];
            end
            build_expected(r);
            n = 0;
            for (int h = 16; h <= 271; h++) begin
                check_pxl($sformatf("obj_pxl[%0d] scene %0d", h, r), exp_line[h], cap_line[h]);
                if (cap_line[h].pal != 0) n++;
            end
            check_count($sformatf("opaque count scene %0d", r), scene_cnt[r], n);
        end
        $display("errors: pixel=%0d scan_done=%0d count=%0d", pxl_err, bit_err, cnt_err);
        if (pxl_err + bit_err + cnt_err == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== flist.f ====
video_pkg.sv
obj_pkg.sv
obj_timing.sv
obj_attr_ram.sv
obj_draw.sv
obj_line_buffer.sv
obj_top.sv
tb_clk_gen.sv
obj_tb.sv
